// ==== tb.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_inst_decode.sv
hdl/rv_control.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_datapath.sv
hdl/rv_core.sv
tb/rv_iss_pkg.sv
tb/rv_core_tb.sv

// ==== Makefile ====
TOOL      = verilator
TOP       = rv_core_tb
FILELIST  = tb.f
FLAGS     = --binary --timing --assert --timescale 1ns/1ns -j 0
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "No pass message found in $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/rv_core_tb.sv ====
// Testbench for the single-cycle RV32I core
// Drives a random instruction stream, serves the data memory and
// compares PC and store traffic with the instruction-set model

`timescale 1ns/1ns

`include "rv_macros.svh"

module rv_core_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_INSTS    = 2000;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_INSTS + 50) * CLK_PERIOD;

  logic          clock;
  logic          arst_n;
  rv_pkg::word_t inst;
  rv_pkg::word_t data_mem_read_data;
  rv_pkg::word_t pc;
  rv_pkg::word_t data_mem_address;
  rv_pkg::word_t data_mem_write_data;
  logic          data_mem_write_enable;

  int error_count;
  int check_count;
  int mem_version;

  rv_core dut (
    .clock                 (clock),
    .arst_n                (arst_n),
    .inst                  (inst),
    .data_mem_read_data    (data_mem_read_data),
    .pc                    (pc),
    .data_mem_address      (data_mem_address),
    .data_mem_write_data   (data_mem_write_data),
    .data_mem_write_enable (data_mem_write_enable)
  );

  initial begin
    clock = 1'b1;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Zero-delay data memory read that follows the model memory
  initial begin
    forever begin
      data_mem_read_data = rv_iss_pkg::read_word(data_mem_address);
      @(data_mem_address or mem_version);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the instruction stream completed");
    $display("Simulation FAILED");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Stimulus and checks
  // ----------------------------------------------------------------------
  function automatic rv_pkg::word_t random_inst();
    int unsigned pick;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [6:0]  op;
    pick  = $urandom_range(0, 99);
    rd    = 5'($urandom_range(0, 7));
    rs1   = 5'($urandom_range(0, 7));
    rs2   = 5'($urandom_range(0, 7));
    f3    = 3'($urandom_range(0, 7));
    f7    = $urandom_range(0, 1) ? 7'h20 : 7'h00;
    imm12 = 12'($urandom);
    imm20 = 20'($urandom);
    if (pick < 22) begin
      // Shift immediates carry funct7 in the upper bits
      if (f3 == 3'd1 || f3 == 3'd5) begin
        if (f3 == 3'd1) begin
          f7 = 7'h00;
        end
        imm12 = {f7, imm12[4:0]};
      end
      return {imm12, rs1, f3, rd, `RV_OP_IMM};
    end else if (pick < 42) begin
      if (f3 != 3'd0 && f3 != 3'd5) begin
        f7 = 7'h00;
      end
      return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    end else if (pick < 48) begin
      return {imm20, rd, `RV_OP_LUI};
    end else if (pick < 53) begin
      return {imm20, rd, `RV_OP_AUIPC};
    end else if (pick < 58) begin
      return {imm20, rd, `RV_OP_JAL};
    end else if (pick < 63) begin
      return {imm12, rs1, 3'b000, rd, `RV_OP_JALR};
    end else if (pick < 76) begin
      // BEQ, BNE, BLT, BGE, BLTU, BGEU
      f3 = 3'($urandom_range(0, 5));
      if (f3 >= 3'd2) begin
        f3 = f3 + 3'd2;
      end
      return {imm12[11:5], rs2, rs1, f3, imm12[4:0], `RV_OP_BRANCH};
    end
    // Small aligned offsets half of the time so loads hit earlier stores
    if ($urandom_range(0, 1) == 1) begin
      imm12 = {7'b0, 3'($urandom_range(0, 7)), 2'b00};
    end
    if (pick < 87) begin
      return {imm12, rs1, 3'b010, rd, `RV_OP_LOAD};
    end else if (pick < 97) begin
      return {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], `RV_OP_STORE};
    end
    // Low opcode bits other than 11 are never a supported instruction
    op = {5'($urandom), 2'($urandom_range(0, 2))};
    return {25'($urandom), op};
  endfunction

  // SW with random registers and offset
  function automatic rv_pkg::word_t random_store();
    return {7'($urandom), 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)), 3'b010,
            5'($urandom), `RV_OP_STORE};
  endfunction

  task automatic check_word(input string name, input rv_pkg::word_t expected,
                            input rv_pkg::word_t actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic wait_sample();
    @(negedge clock);
    #(CLK_PERIOD / 2 - DRIVE_DELAY);
  endtask

  task automatic wait_drive();
    @(posedge clock);
    #(DRIVE_DELAY);
  endtask

  task automatic check_reset(input int cycle);
    check_word($sformatf("reset pc, cycle %0d", cycle), `RV_INITIAL_PC, pc);
    check_word($sformatf("reset store enable, cycle %0d", cycle), 32'd0,
               {31'b0, data_mem_write_enable});
  endtask

  // Compare with the model before it executes the same instruction
  task automatic check_and_step(input int index);
    bit            store_active;
    rv_pkg::word_t store_address;
    rv_pkg::word_t store_data;
    rv_iss_pkg::store_effect(inst, store_active, store_address, store_data);
    check_word($sformatf("pc, instruction %0d", index), rv_iss_pkg::pc, pc);
    check_word($sformatf("store enable, instruction %0d", index), {31'b0, store_active},
               {31'b0, data_mem_write_enable});
    if (store_active) begin
      check_word($sformatf("store address, instruction %0d", index), store_address,
                 data_mem_address);
      check_word($sformatf("store data, instruction %0d", index), store_data,
                 data_mem_write_data);
    end
    rv_iss_pkg::step(inst);
    mem_version++;
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
    mem_version = 0;
    arst_n      = 1'b0;
    void'($urandom(61));
    rv_iss_pkg::reset_state();
    inst = random_store();

    // Stores only while reset is held
    for (int cycle = 0; cycle < RESET_CYCLES; cycle++) begin
      wait_sample();
      check_reset(cycle);
      wait_drive();
      inst = random_store();
    end
    arst_n = 1'b1;

    for (int index = 0; index < NUM_INSTS; index++) begin
      wait_sample();
      check_and_step(index);
      wait_drive();
      inst = random_inst();
    end

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/rv_iss_pkg.sv ====
// RV32I instruction-set model for the core testbench
// Holds architectural registers, PC and a sparse word memory

`include "rv_macros.svh"

package rv_iss_pkg;

  rv_pkg::word_t regs [32];
  rv_pkg::word_t pc;
  // Word storage keyed by address bits 31:2
  rv_pkg::word_t mem [bit [29:0]];

  function automatic void reset_state();
    foreach (regs[i]) begin
      regs[i] = '0;
    end
    pc = `RV_INITIAL_PC;
    mem.delete();
  endfunction

  // Unwritten words return a pattern built from their own address
  function automatic rv_pkg::word_t read_word(input rv_pkg::word_t address);
    if (mem.exists(address[31:2])) begin
      return mem[address[31:2]];
    end
    return {address[31:2], 2'b00} ^ 32'h5a3c_96e1;
  endfunction

  // ----------------------------------------------------------------------
  // Immediate formats, as laid out in the ISA manual
  // ----------------------------------------------------------------------
  function automatic rv_pkg::word_t imm_i(input rv_pkg::word_t w);
    return {{20{w[31]}}, w[31:20]};
  endfunction

  function automatic rv_pkg::word_t imm_s(input rv_pkg::word_t w);
    return {{20{w[31]}}, w[31:25], w[11:7]};
  endfunction

  function automatic rv_pkg::word_t imm_b(input rv_pkg::word_t w);
    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  function automatic rv_pkg::word_t imm_u(input rv_pkg::word_t w);
    return {w[31:12], 12'b0};
  endfunction

  function automatic rv_pkg::word_t imm_j(input rv_pkg::word_t w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  // Integer op by funct3, alt selects SUB or SRA
  function automatic rv_pkg::word_t arith(input logic [2:0] f3, input bit alt,
                                          input rv_pkg::word_t a, input rv_pkg::word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branch_taken(input logic [2:0] f3, input rv_pkg::word_t a,
                                      input rv_pkg::word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Store that the next instruction performs, seen from the current state
  function automatic void store_effect(input rv_pkg::word_t w, output bit active,
                                       output rv_pkg::word_t address,
                                       output rv_pkg::word_t data);
    active  = (w[6:0] == `RV_OP_STORE);
    address = regs[w[19:15]] + imm_s(w);
    data    = regs[w[24:20]];
  endfunction

  // ----------------------------------------------------------------------
  // Execute one instruction
  // ----------------------------------------------------------------------
  function automatic void step(input rv_pkg::word_t w);
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t result;
    rv_pkg::word_t next_pc;
    rv_pkg::word_t address;
    bit            write_rd;
    a        = regs[w[19:15]];
    b        = regs[w[24:20]];
    result   = '0;
    address  = '0;
    write_rd = 1'b1;
    next_pc  = pc + 32'd4;
    case (w[6:0])
      `RV_OP_LUI:   result = imm_u(w);
      `RV_OP_AUIPC: result = pc + imm_u(w);
      `RV_OP_JAL: begin
        result  = pc + 32'd4;
        next_pc = pc + imm_j(w);
      end
      `RV_OP_JALR: begin
        result  = pc + 32'd4;
        next_pc = (a + imm_i(w)) & ~32'd1;
      end
      `RV_OP_BRANCH: begin
        write_rd = 1'b0;
        if (branch_taken(w[14:12], a, b)) begin
          next_pc = pc + imm_b(w);
        end
      end
      `RV_OP_LOAD:  result = read_word(a + imm_i(w));
      `RV_OP_STORE: begin
        write_rd = 1'b0;
        address  = a + imm_s(w);
        mem[address[31:2]] = b;
      end
      `RV_OP_IMM:   result = arith(w[14:12], (w[14:12] == 3'd5) && w[30], a, imm_i(w));
      `RV_OP_REG:   result = arith(w[14:12], w[30], a, b);
      default:      write_rd = 1'b0;
    endcase
    // x0 stays zero
    if (write_rd && w[11:7] != 5'd0) begin
      regs[w[11:7]] = result;
    end
    pc = next_pc;
  endfunction

endpackage

// ==== hdl/rv_core.sv ====
// RV32I single-cycle core
// Joins control and data path to the instruction and data memory ports

`timescale 1ns/1ns

module rv_core (
  input  logic          clock,
  input  logic          arst_n,
  input  rv_pkg::word_t inst,
  input  rv_pkg::word_t data_mem_read_data,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t data_mem_address,
  output rv_pkg::word_t data_mem_write_data,
  output logic          data_mem_write_enable
);

  rv_pkg::opcode_t inst_opcode;
  rv_pkg::funct3_t inst_funct3;
  rv_pkg::funct7_t inst_funct7;
  logic            alu_zero;
  logic            regfile_write_enable;
  rv_pkg::alu_fn_t alu_function;
  logic            operand_a_select;
  logic            operand_b_select;
  rv_pkg::pc_sel_t next_pc_select;
  rv_pkg::wb_sel_t wb_select;

  rv_control u_control (
    .arst_n                (arst_n),
    .opcode                (inst_opcode),
    .funct3                (inst_funct3),
    .funct7                (inst_funct7),
    .alu_zero              (alu_zero),
    .regfile_write_enable  (regfile_write_enable),
    .data_mem_write_enable (data_mem_write_enable),
    .alu_function          (alu_function),
    .operand_a_select      (operand_a_select),
    .operand_b_select      (operand_b_select),
    .next_pc_select        (next_pc_select),
    .wb_select             (wb_select)
  );

  rv_datapath u_datapath (
    .clock                (clock),
    .arst_n               (arst_n),
    .inst                 (inst),
    .data_mem_read_data   (data_mem_read_data),
    .regfile_write_enable (regfile_write_enable),
    .alu_function         (alu_function),
    .operand_a_select     (operand_a_select),
    .operand_b_select     (operand_b_select),
    .next_pc_select       (next_pc_select),
    .wb_select            (wb_select),
    .pc                   (pc),
    .data_mem_address     (data_mem_address),
    .data_mem_write_data  (data_mem_write_data),
    .alu_zero             (alu_zero),
    .inst_opcode          (inst_opcode),
    .inst_funct3          (inst_funct3),
    .inst_funct7          (inst_funct7)
  );

endmodule

// ==== hdl/rv_datapath.sv ====
// RV32I single-cycle data path
// PC register, decode, register file, ALU, next-PC selection
// and register writeback selection

`timescale 1ns/1ns

`include "rv_macros.svh"

module rv_datapath (
  input  logic            clock,
  input  logic            arst_n,
  input  rv_pkg::word_t   inst,
  input  rv_pkg::word_t   data_mem_read_data,
  input  logic            regfile_write_enable,
  input  rv_pkg::alu_fn_t alu_function,
  input  logic            operand_a_select,
  input  logic            operand_b_select,
  input  rv_pkg::pc_sel_t next_pc_select,
  input  rv_pkg::wb_sel_t wb_select,
  output rv_pkg::word_t   pc,
  output rv_pkg::word_t   data_mem_address,
  output rv_pkg::word_t   data_mem_write_data,
  output logic            alu_zero,
  output rv_pkg::opcode_t inst_opcode,
  output rv_pkg::funct3_t inst_funct3,
  output rv_pkg::funct7_t inst_funct7
);

  rv_pkg::reg_addr_t rs1_address;
  rv_pkg::reg_addr_t rs2_address;
  rv_pkg::reg_addr_t rd_address;
  rv_pkg::word_t     immediate;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  rv_pkg::word_t     rd_data;
  rv_pkg::word_t     operand_a;
  rv_pkg::word_t     operand_b;
  rv_pkg::word_t     alu_result;
  rv_pkg::word_t     pc_plus4;
  rv_pkg::word_t     pc_plus_imm;
  rv_pkg::word_t     jalr_target;
  rv_pkg::word_t     next_pc;

  rv_inst_decode u_decode (
    .inst      (inst),
    .rs1       (rs1_address),
    .rs2       (rs2_address),
    .rd        (rd_address),
    .opcode    (inst_opcode),
    .funct3    (inst_funct3),
    .funct7    (inst_funct7),
    .immediate (immediate)
  );

  rv_regfile u_regfile (
    .clock        (clock),
    .arst_n       (arst_n),
    .rs1_address  (rs1_address),
    .rs2_address  (rs2_address),
    .write_enable (regfile_write_enable),
    .rd_address   (rd_address),
    .rd_data      (rd_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  assign operand_a = operand_a_select ? pc : rs1_data;
  assign operand_b = operand_b_select ? immediate : rs2_data;

  rv_alu u_alu (
    .alu_function      (alu_function),
    .operand_a         (operand_a),
    .operand_b         (operand_b),
    .result            (alu_result),
    .result_equal_zero (alu_zero)
  );

  assign data_mem_address    = alu_result;
  assign data_mem_write_data = rs2_data;

  // ----------------------------------------------------------------------
  // Next PC
  // ----------------------------------------------------------------------
  assign pc_plus4    = pc + 32'd4;
  assign pc_plus_imm = pc + immediate;
  // JALR target has bit 0 cleared
  assign jalr_target = {alu_result[31:1], 1'b0};

  always_comb begin
    case (next_pc_select)
      rv_pkg::PC_BRANCH: next_pc = pc_plus_imm;
      rv_pkg::PC_JALR:   next_pc = jalr_target;
      default:           next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RV_INITIAL_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // ----------------------------------------------------------------------
  // Writeback
  // ----------------------------------------------------------------------
  always_comb begin
    case (wb_select)
      rv_pkg::WB_MEM:      rd_data = data_mem_read_data;
      rv_pkg::WB_PC_PLUS4: rd_data = pc_plus4;
      rv_pkg::WB_IMM:      rd_data = immediate;
      default:             rd_data = alu_result;
    endcase
  end

endmodule

// ==== hdl/rv_alu.sv ====
// RV32I ALU
// Add, subtract, logic, shifts and compares, with a zero flag
// used for branch resolution

`timescale 1ns/1ns

module rv_alu (
  input  rv_pkg::alu_fn_t alu_function,
  input  rv_pkg::word_t   operand_a,
  input  rv_pkg::word_t   operand_b,
  output rv_pkg::word_t   result,
  output logic            result_equal_zero
);

  logic [4:0] shamt;

  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_function)
      rv_pkg::ALU_ADD:    result = operand_a + operand_b;
      rv_pkg::ALU_SUB:    result = operand_a - operand_b;
      rv_pkg::ALU_SLL:    result = operand_a << shamt;
      rv_pkg::ALU_SLT:    result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      rv_pkg::ALU_SLTU:   result = {31'b0, operand_a < operand_b};
      rv_pkg::ALU_XOR:    result = operand_a ^ operand_b;
      rv_pkg::ALU_SRL:    result = operand_a >> shamt;
      rv_pkg::ALU_SRA:    result = $unsigned($signed(operand_a) >>> shamt);
      rv_pkg::ALU_OR:     result = operand_a | operand_b;
      rv_pkg::ALU_AND:    result = operand_a & operand_b;
      rv_pkg::ALU_PASS_B: result = operand_b;
      default:            result = '0;
    endcase
  end

  // Flag covers the full result word
  assign result_equal_zero = (result == '0);

endmodule

// ==== hdl/rv_regfile.sv ====
// RV32I register file
// Two combinational read ports, one write port, x0 reads as zero

`timescale 1ns/1ns

`include "rv_macros.svh"

module rv_regfile (
  input  logic              clock,
  input  logic              arst_n,
  input  rv_pkg::reg_addr_t rs1_address,
  input  rv_pkg::reg_addr_t rs2_address,
  input  logic              write_enable,
  input  rv_pkg::reg_addr_t rd_address,
  input  rv_pkg::word_t     rd_data,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  rv_pkg::word_t regs [`RV_REG_COUNT];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && rd_address != '0) begin
      regs[rd_address] <= rd_data;
    end
  end

  // x0 is never written, so the array entry stays zero
  assign rs1_data = regs[rs1_address];
  assign rs2_data = regs[rs2_address];

endmodule

// ==== hdl/rv_control.sv ====
// RV32I control unit
// Maps opcode and function fields to data path selects and enables,
// and resolves branches from the ALU zero flag

`timescale 1ns/1ns

`include "rv_macros.svh"

module rv_control (
  input  logic              arst_n,
  input  rv_pkg::opcode_t   opcode,
  input  rv_pkg::funct3_t   funct3,
  input  rv_pkg::funct7_t   funct7,
  input  logic              alu_zero,
  output logic              regfile_write_enable,
  output logic              data_mem_write_enable,
  output rv_pkg::alu_fn_t   alu_function,
  output logic              operand_a_select,
  output logic              operand_b_select,
  output rv_pkg::pc_sel_t   next_pc_select,
  output rv_pkg::wb_sel_t   wb_select
);

  logic reg_write;
  logic mem_write;
  logic branch_legal;
  logic branch_taken;

  // Integer op from funct3, alt picks SUB or SRA
  function automatic rv_pkg::alu_fn_t arith_fn(input rv_pkg::funct3_t f3, input logic alt);
    case (f3)
      3'b000:  arith_fn = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  arith_fn = rv_pkg::ALU_SLL;
      3'b010:  arith_fn = rv_pkg::ALU_SLT;
      3'b011:  arith_fn = rv_pkg::ALU_SLTU;
      3'b100:  arith_fn = rv_pkg::ALU_XOR;
      3'b101:  arith_fn = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  arith_fn = rv_pkg::ALU_OR;
      default: arith_fn = rv_pkg::ALU_AND;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Branch resolution
  // ----------------------------------------------------------------------
  // funct3 010 and 011 are not branches
  assign branch_legal = (funct3[2:1] != 2'b01);
  // BEQ, BGE, BGEU take on zero; BNE, BLT, BLTU on non-zero
  assign branch_taken = branch_legal & (alu_zero ^ funct3[0] ^ funct3[2]);

  // ----------------------------------------------------------------------
  // Opcode decode
  // ----------------------------------------------------------------------
  always_comb begin
    reg_write        = 1'b0;
    mem_write        = 1'b0;
    alu_function     = rv_pkg::ALU_ADD;
    operand_a_select = 1'b0;
    operand_b_select = 1'b1;
    next_pc_select   = rv_pkg::PC_PLUS4;
    wb_select        = rv_pkg::WB_ALU;
    case (opcode)
      `RV_OP_LUI: begin
        reg_write    = 1'b1;
        alu_function = rv_pkg::ALU_PASS_B;
      end
      `RV_OP_AUIPC: begin
        reg_write        = 1'b1;
        operand_a_select = 1'b1;
      end
      `RV_OP_JAL: begin
        reg_write      = 1'b1;
        next_pc_select = rv_pkg::PC_BRANCH;
        wb_select      = rv_pkg::WB_PC_PLUS4;
      end
      `RV_OP_JALR: begin
        reg_write      = 1'b1;
        next_pc_select = rv_pkg::PC_JALR;
        wb_select      = rv_pkg::WB_PC_PLUS4;
      end
      `RV_OP_BRANCH: begin
        operand_b_select = 1'b0;
        case (funct3[2:1])
          2'b10:   alu_function = rv_pkg::ALU_SLT;
          2'b11:   alu_function = rv_pkg::ALU_SLTU;
          default: alu_function = rv_pkg::ALU_SUB;
        endcase
        if (branch_taken) begin
          next_pc_select = rv_pkg::PC_BRANCH;
        end
      end
      `RV_OP_LOAD: begin
        reg_write = 1'b1;
        wb_select = rv_pkg::WB_MEM;
      end
      `RV_OP_STORE: begin
        mem_write = 1'b1;
      end
      `RV_OP_IMM: begin
        reg_write    = 1'b1;
        // Only the shift-right immediate uses funct7 bit 5
        alu_function = arith_fn(funct3, funct7[5] & (funct3 == 3'b101));
      end
      `RV_OP_REG: begin
        reg_write        = 1'b1;
        operand_b_select = 1'b0;
        alu_function     = arith_fn(funct3, funct7[5]);
      end
      default: begin
        // No-operation, falls through to PC+4
      end
    endcase
  end

  assign regfile_write_enable  = reg_write & arst_n;
  assign data_mem_write_enable = mem_write & arst_n;

endmodule

// ==== hdl/rv_inst_decode.sv ====
// RV32I instruction decoder
// Slices the fixed fields and builds the sign-extended immediate

`timescale 1ns/1ns

`include "rv_macros.svh"

module rv_inst_decode (
  input  rv_pkg::word_t     inst,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::opcode_t   opcode,
  output rv_pkg::funct3_t   funct3,
  output rv_pkg::funct7_t   funct7,
  output rv_pkg::word_t     immediate
);

  // Fixed field positions, shared by all formats
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // Immediate format follows the opcode, sign bit is always inst[31]
  always_comb begin
    case (opcode)
      `RV_OP_IMM, `RV_OP_LOAD, `RV_OP_JALR: begin
        immediate = {{20{inst[31]}}, inst[31:20]};
      end
      `RV_OP_STORE: begin
        immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      `RV_OP_BRANCH: begin
        immediate = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      `RV_OP_LUI, `RV_OP_AUIPC: begin
        immediate = {inst[31:12], 12'h000};
      end
      `RV_OP_JAL: begin
        immediate = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: begin
        immediate = '0;
      end
    endcase
  end

endmodule

// ==== hdl/rv_pkg.sv ====
// RV32I core types
// Width typedefs and the select codes shared by control and data path

`include "rv_macros.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]              word_t;
  typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_addr_t;
  typedef logic [6:0]                       opcode_t;
  typedef logic [2:0]                       funct3_t;
  typedef logic [6:0]                       funct7_t;

  // ----------------------------------------------------------------------
  // ALU functions
  // ----------------------------------------------------------------------
  typedef logic [3:0] alu_fn_t;

  localparam alu_fn_t ALU_ADD    = 4'd0;
  localparam alu_fn_t ALU_SUB    = 4'd1;
  localparam alu_fn_t ALU_SLL    = 4'd2;
  localparam alu_fn_t ALU_SLT    = 4'd3;
  localparam alu_fn_t ALU_SLTU   = 4'd4;
  localparam alu_fn_t ALU_XOR    = 4'd5;
  localparam alu_fn_t ALU_SRL    = 4'd6;
  localparam alu_fn_t ALU_SRA    = 4'd7;
  localparam alu_fn_t ALU_OR     = 4'd8;
  localparam alu_fn_t ALU_AND    = 4'd9;
  // Operand B straight through, for LUI
  localparam alu_fn_t ALU_PASS_B = 4'd10;

  // ----------------------------------------------------------------------
  // Next-PC and writeback sources
  // ----------------------------------------------------------------------
  typedef logic [1:0] pc_sel_t;

  localparam pc_sel_t PC_PLUS4  = 2'd0;
  localparam pc_sel_t PC_BRANCH = 2'd1;
  localparam pc_sel_t PC_JALR   = 2'd2;

  typedef logic [1:0] wb_sel_t;

  localparam wb_sel_t WB_ALU      = 2'd0;
  localparam wb_sel_t WB_MEM      = 2'd1;
  localparam wb_sel_t WB_PC_PLUS4 = 2'd2;
  localparam wb_sel_t WB_IMM      = 2'd3;

endpackage

// ==== hdl/rv_macros.svh ====
// RV32I core parameters
// Data width, register count, reset PC and the major opcode values
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define RV_XLEN       32
`define RV_REG_COUNT  32
`define RV_INITIAL_PC 32'h0000_0000

// Major opcodes, instruction bits 6:0
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

`endif
